// File: Bender.yml
package:
  name: sys_core

sources:
  - hps_cfg_pkg.sv
  - video_pkg.sv
  - hps_cmd_rx.sv
  - sys_cfg_regs.sv
  - ar_muldiv.sv
  - video_window.sv
  - sync_polarity.sv
  - sys_core_top.sv
  - target: simulation
    files:
      - sys_core_chk.sv
      - tb_sys_core.sv

// File: ar_muldiv.sv
////////////////////////////////////////
// Serial unsigned multiply then divide
// result = mul1 * mul2 / div, low bits
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ar_muldiv
	import video_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_start,
	input  dim_t i_mul1,
	input  dim_t i_mul2,
	input  dim_t i_div,
	output logic o_busy,
	output dim_t o_result
);

	typedef enum logic [1:0] {MD_IDLE, MD_MUL, MD_DIV} md_state_e;

	md_state_e          state;
	logic [3:0]         step;
	logic [2*DIM_W-1:0] acc;
	logic [2*DIM_W-1:0] mcand;
	dim_t               mplier;
	dim_t               div_q;
	dim_t               rem;

	logic [DIM_W:0] t1, r1, t2, r2;
	logic           q1, q2;

	// Two restoring steps per clock, dividend shifted out of acc MSB first
	assign t1 = {rem, acc[2*DIM_W-1]};
	assign q1 = t1 >= {1'b0, div_q};
	assign r1 = q1 ? t1 - {1'b0, div_q} : t1;
	assign t2 = {r1[DIM_W-1:0], acc[2*DIM_W-2]};
	assign q2 = t2 >= {1'b0, div_q};
	assign r2 = q2 ? t2 - {1'b0, div_q} : t2;

	assign o_busy   = state != MD_IDLE;
	assign o_result = acc[DIM_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= MD_IDLE;
			step  <= '0;
		end else begin
			case (state)
				MD_IDLE: if (i_start) begin
					state <= MD_MUL;
					step  <= 4'(DIM_W - 1);
				end
				MD_MUL: begin
					step <= step - 4'd1;
					if (step == '0) begin
						state <= MD_DIV;
						// Whole product as dividend, two bits per clock
						step  <= 4'(DIM_W - 1);
					end
				end
				MD_DIV: begin
					step <= step - 4'd1;
					if (step == '0)
						state <= MD_IDLE;
				end
				default: state <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		case (state)
			MD_IDLE: if (i_start) begin
				acc    <= '0;
				mcand  <= {{DIM_W{1'b0}}, i_mul1};
				mplier <= i_mul2;
				div_q  <= i_div;
				rem    <= '0;
			end
			// Shift and add, one multiplier bit per clock
			MD_MUL: begin
				if (mplier[0])
					acc <= acc + mcand;
				mcand  <= mcand << 1;
				mplier <= mplier >> 1;
			end
			// Quotient bits enter at the bottom as the dividend leaves the top
			MD_DIV: begin
				acc <= {acc[2*DIM_W-3:0], q1, q2};
				rem <= r2[DIM_W-1:0];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hps_cfg_pkg.sv
////////////////////////////////////////
// Host side definitions
// Host word, command opcodes, timing frame layout
// LED and scaling register types
////////////////////////////////////////
`default_nettype none

package hps_cfg_pkg;

	localparam int HOST_W = 16;
	localparam int SET_W  = 12;

	// Timing frame layout, only width and height are kept
	localparam int TIM_WORDS = 8;
	localparam int TIM_W_IDX = 0;
	localparam int TIM_H_IDX = 4;

	typedef logic [HOST_W-1:0] host_word_t;

	// First word of a frame, low byte
	typedef enum logic [7:0] {
		OP_TIMING = 8'h20,
		OP_LED    = 8'h25,
		OP_VSET   = 8'h27,
		OP_HSET   = 8'h37
	} hps_op_e;

	typedef struct packed {
		logic [7:0] override;
		logic [7:0] state;
	} led_cfg_t;

	typedef struct packed {
		logic             free_scale;
		logic [SET_W-1:0] hset;
		logic [SET_W-1:0] vset;
	} scale_cfg_t;

endpackage

`default_nettype wire

// File: hps_cmd_rx.sv
////////////////////////////////////////
// Host link receiver
// Four-phase req/ack, one strobe per word
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_rx
	import hps_cfg_pkg::*;
(
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_io_sel,
	input  logic       i_io_req,
	input  host_word_t i_io_data,
	output logic       o_io_ack,
	output logic       o_word_stb,
	output logic       o_word_first,
	output host_word_t o_word
);

	logic in_frame;
	logic take;

	// New word when req is up and not yet answered
	assign take = i_io_req && !o_io_ack;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_io_ack     <= 1'b0;
			o_word_stb   <= 1'b0;
			o_word_first <= 1'b0;
			in_frame     <= 1'b0;
		end else begin
			o_word_stb <= 1'b0;
			if (take) begin
				o_io_ack     <= 1'b1;
				o_word_stb   <= i_io_sel;
				o_word_first <= !in_frame;
				in_frame     <= 1'b1;
			end else if (!i_io_req) begin
				o_io_ack <= 1'b0;
			end
			// Deselect closes the frame
			if (!i_io_sel)
				in_frame <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take)
			o_word <= i_io_data;
	end

endmodule

`default_nettype wire

// File: project.f
hps_cfg_pkg.sv
video_pkg.sv
hps_cmd_rx.sv
sys_cfg_regs.sv
ar_muldiv.sv
video_window.sv
sync_polarity.sv
sys_core_top.sv
sys_core_chk.sv
tb_sys_core.sv

// File: sync_polarity.sv
////////////////////////////////////////
// Sync polarity normaliser
// High and low run lengths pick the polarity
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sync_polarity
	import video_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_d;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] run_cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;

	// Longer high run means the pulse is active low
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_d   <= 1'b0;
			pol      <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			sync_d <= i_sync;
			if (sync_d != i_sync) begin
				run_cnt <= '0;
				if (i_sync) begin
					low_len <= run_cnt;
					pol     <= high_len > run_cnt;
				end else begin
					high_len <= run_cnt;
					pol      <= run_cnt > low_len;
				end
			end else if (run_cnt != '1) begin
				run_cnt <= run_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sys_cfg_regs.sv
////////////////////////////////////////
// Command decoder
// Opcode latch, parameter word count
// Timing size, LED and scaling registers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_cfg_regs
	import hps_cfg_pkg::*, video_pkg::*;
(
	input  logic        clk_sys,
	input  logic        resetd,
	input  logic        i_word_stb,
	input  logic        i_word_first,
	input  host_word_t  i_word,
	output led_cfg_t    o_led,
	output video_size_t o_size,
	output scale_cfg_t  o_scale
);

	hps_op_e    op;
	logic       cmd_vld;
	logic [3:0] word_cnt;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			op       <= OP_TIMING;
			cmd_vld  <= 1'b0;
			word_cnt <= '0;
			o_led    <= '0;
			o_size   <= '{width: DEF_WIDTH, height: DEF_HEIGHT};
			o_scale  <= '0;
		end else if (i_word_stb) begin
			if (i_word_first) begin
				// Opcode word starts a new parameter count
				op       <= hps_op_e'(i_word[7:0]);
				cmd_vld  <= 1'b1;
				word_cnt <= '0;
			end else if (cmd_vld) begin
				if (word_cnt != 4'(TIM_WORDS))
					word_cnt <= word_cnt + 4'd1;

				case (op)
					// Porch and sync words pass through unused
					OP_TIMING: begin
						if (word_cnt == 4'(TIM_W_IDX))
							o_size.width <= i_word[DIM_W-1:0];
						else if (word_cnt == 4'(TIM_H_IDX))
							o_size.height <= i_word[DIM_W-1:0];
					end

					OP_LED: begin
						o_led <= led_cfg_t'(i_word);
					end

					OP_VSET: begin
						o_scale.vset <= i_word[SET_W-1:0];
					end

					OP_HSET: begin
						o_scale.free_scale <= i_word[HOST_W-1];
						o_scale.hset       <= i_word[SET_W-1:0];
					end

					default: begin
						// Unknown opcode, frame is dropped
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: sys_core_chk.sv
////////////////////////////////////////
// Bound checks on the core top level
// Host handshake and window ordering
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_core_chk
	import video_pkg::*;
(
	input logic    clk_sys,
	input logic    resetd,
	input logic    i_io_req,
	input logic    i_io_ack,
	input window_t i_window
);

	int fail_cnt = 0;

	// Ack only answers a pending request
	ack_needs_req: assert property (
		@(posedge clk_sys) disable iff (resetd) $rose(i_io_ack) |-> $past(i_io_req)
	) else begin
		fail_cnt++;
		$error("ack rose without a request");
	end

	ack_low_after_reset: assert property (
		@(posedge clk_sys) resetd |=> !i_io_ack
	) else begin
		fail_cnt++;
		$error("ack high in the cycle after reset");
	end

	// An empty window is the reset value
	window_order: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(i_window != '0) |-> (i_window.hmin <= i_window.hmax && i_window.vmin <= i_window.vmax)
	) else begin
		fail_cnt++;
		$error("window bounds out of order");
	end

endmodule

bind sys_core_top sys_core_chk u_sys_core_chk (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_io_req (i_io_req),
	.i_io_ack (o_io_ack),
	.i_window (o_window)
);

`default_nettype wire

// File: sys_core_top.sv
////////////////////////////////////////
// Core top level
// Host receiver, config registers
// Window calculator, sync normalisers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_core_top
	import hps_cfg_pkg::*, video_pkg::*;
(
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_io_sel,
	input  logic       i_io_req,
	input  host_word_t i_io_data,
	output logic       o_io_ack,
	input  aspect_t    i_aspect,
	input  logic       i_hs_raw,
	input  logic       i_vs_raw,
	output logic       o_hs,
	output logic       o_vs,
	output logic [7:0] o_led,
	output window_t    o_window
);

	logic        word_stb;
	logic        word_first;
	host_word_t  word;
	led_cfg_t    led;
	video_size_t size;
	scale_cfg_t  scale;

	hps_cmd_rx u_hps_cmd_rx (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_sel(i_io_sel), .i_io_req(i_io_req), .i_io_data(i_io_data), .o_io_ack(o_io_ack),
		.o_word_stb(word_stb), .o_word_first(word_first), .o_word(word)
	);

	sys_cfg_regs u_sys_cfg_regs (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_word_stb(word_stb), .i_word_first(word_first), .i_word(word),
		.o_led(led), .o_size(size), .o_scale(scale)
	);

	video_window u_video_window (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_size(size), .i_scale(scale), .i_aspect(i_aspect), .o_window(o_window)
	);

	sync_polarity u_hs_fix (.clk_sys(clk_sys), .resetd(resetd), .i_sync(i_hs_raw), .o_sync(o_hs));
	sync_polarity u_vs_fix (.clk_sys(clk_sys), .resetd(resetd), .i_sync(i_vs_raw), .o_sync(o_vs));

	// No status sources left, bits without override stay dark
	assign o_led = led.override & led.state;

endmodule

`default_nettype wire

// File: tb_sys_core.sv
////////////////////////////////////////
// Testbench for the core top level
// Clock, LFSR, host frame driver
// Reference window model, compare tasks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_sys_core
	import hps_cfg_pkg::*, video_pkg::*;
();

	localparam int CLK_PERIOD    = 10;
	localparam int RESET_CYCLES  = 10;
	localparam int N_TESTS       = 6;
	localparam int SETTLE_CYCLES = 150;
	localparam int ACK_TIMEOUT   = 40;
	localparam int SYNC_PERIOD   = 64;

	typedef struct packed {
		logic       is_led;
		logic [7:0] led;
		window_t    win;
	} check_req_t;

	logic        clk_sys;
	logic        resetd;
	logic        io_sel;
	logic        io_req;
	logic        io_ack;
	host_word_t  io_data;
	aspect_t     aspect;
	logic        hs_raw;
	logic        vs_raw;
	logic        hs;
	logic        vs;
	logic [7:0]  led;
	window_t     window;

	// Shadow of the register state as the host programmed it
	video_size_t m_size;
	scale_cfg_t  m_scale;
	led_cfg_t    m_led;

	logic [31:0] lfsr;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          ack_rises = 0;
	int          ack_falls = 0;
	logic        ack_prev = 1'b0;
	check_req_t  exp_req;
	logic        check_pending = 1'b0;
	host_word_t  frame_words[$];

	sys_core_top u_sys_core_top (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_sel  (io_sel),
		.i_io_req  (io_req),
		.i_io_data (io_data),
		.o_io_ack  (io_ack),
		.i_aspect  (aspect),
		.i_hs_raw  (hs_raw),
		.i_vs_raw  (vs_raw),
		.o_hs      (hs),
		.o_vs      (vs),
		.o_led     (led),
		.o_window  (window)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hd000_0001 : lfsr >> 1;
		end
		return v;
	endfunction

	// Expected window from sizes, limits and aspect
	function automatic window_t ref_window(video_size_t sz, scale_cfg_t sc, aspect_t ar);
		int      lw;
		int      lh;
		int      w;
		int      h;
		int      hmin;
		int      vmin;
		window_t r;
		lw = (sc.hset != 0 && sc.hset < sz.width) ? sc.hset : sz.width;
		lh = (sc.vset != 0 && sc.vset < sz.height) ? sc.vset : sz.height;
		if (sc.free_scale || ar.arx == 0 || ar.ary == 0) begin
			w = lw;
			h = lh;
		end else begin
			w = (lh * ar.arx / ar.ary) % 4096;
			h = (lw * ar.ary / ar.arx) % 4096;
		end
		if (w > lw)
			w = lw;
		if (h > lh)
			h = lh;
		hmin   = (sz.width - w) / 2;
		vmin   = (sz.height - h) / 2;
		r.hmin = dim_t'(hmin);
		r.hmax = dim_t'(hmin + w - 1);
		r.vmin = dim_t'(vmin);
		r.vmax = dim_t'(vmin + h - 1);
		return r;
	endfunction

	task automatic check_window(input window_t exp, input window_t got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: window exp h %0d..%0d v %0d..%0d, got h %0d..%0d v %0d..%0d",
				$time, exp.hmin, exp.hmax, exp.vmin, exp.vmax,
				got.hmin, got.hmax, got.vmin, got.vmax);
		end
	endtask

	task automatic check_led(input logic [7:0] exp, input logic [7:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: led exp %h, got %h", $time, exp, got);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s exp %b, got %b", $time, what, exp, got);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int got);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0t: %s exp %0d, got %0d", $time, what, exp, got);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// Four-phase word transfer with ack timeouts
	task automatic send_word(input host_word_t w);
		int waited;
		waited = 0;
		while (io_ack && waited < ACK_TIMEOUT) begin
			next_cycle();
			waited++;
		end
		io_data = w;
		io_req  = 1'b1;
		waited  = 0;
		do begin
			next_cycle();
			waited++;
		end while (!io_ack && waited < ACK_TIMEOUT);
		if (!io_ack) begin
			errors++;
			$display("No ack from DUT for host word %h at %0t", w, $time);
		end
		io_req = 1'b0;
		waited = 0;
		while (io_ack && waited < ACK_TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (io_ack) begin
			errors++;
			$display("Ack stuck high after host word %h at %0t", w, $time);
		end
	endtask

	task automatic send_frame();
		next_cycle();
		io_sel = 1'b1;
		foreach (frame_words[i])
			send_word(frame_words[i]);
		next_cycle();
		io_sel = 1'b0;
		next_cycle();
		frame_words.delete();
	endtask

	task automatic set_timing(input dim_t w, input dim_t h);
		frame_words.push_back(host_word_t'(OP_TIMING));
		for (int i = 0; i < TIM_WORDS; i++) begin
			if (i == TIM_W_IDX)
				frame_words.push_back(host_word_t'(w));
			else if (i == TIM_H_IDX)
				frame_words.push_back(host_word_t'(h));
			else
				frame_words.push_back(host_word_t'(rand_bits(16)));
		end
		send_frame();
		m_size.width  = w;
		m_size.height = h;
	endtask

	task automatic set_led(input host_word_t v);
		frame_words.push_back(host_word_t'(OP_LED));
		frame_words.push_back(v);
		send_frame();
		m_led = led_cfg_t'(v);
	endtask

	task automatic set_vset(input dim_t v);
		frame_words.push_back(host_word_t'(OP_VSET));
		frame_words.push_back({4'h0, v});
		send_frame();
		m_scale.vset = v;
	endtask

	task automatic set_hset(input logic fs, input dim_t v);
		frame_words.push_back(host_word_t'(OP_HSET));
		frame_words.push_back({fs, 3'b000, v});
		send_frame();
		m_scale.free_scale = fs;
		m_scale.hset       = v;
	endtask

	task automatic set_aspect(input dim_t arx, input dim_t ary);
		next_cycle();
		aspect.arx = arx;
		aspect.ary = ary;
	endtask

	task automatic set_random_aspect();
		set_aspect(dim_t'(1 + rand_bits(4)), dim_t'(1 + rand_bits(4)));
	endtask

	// Hand one expected result to the compare process
	task automatic expect_window();
		repeat (SETTLE_CYCLES) next_cycle();
		exp_req.is_led = 1'b0;
		exp_req.win    = ref_window(m_size, m_scale, aspect);
		check_pending  = 1'b1;
		wait (!check_pending);
	endtask

	task automatic expect_led();
		repeat (2) next_cycle();
		exp_req.is_led = 1'b1;
		exp_req.led    = m_led.override & m_led.state;
		check_pending  = 1'b1;
		wait (!check_pending);
	endtask

	// Two periods to learn the polarity, the third one is checked
	task automatic run_sync(input int hs_high, input int vs_high);
		logic hs_inv;
		logic vs_inv;
		hs_inv = hs_high > SYNC_PERIOD - hs_high;
		vs_inv = vs_high > SYNC_PERIOD - vs_high;
		for (int p = 0; p < 3; p++) begin
			for (int i = 0; i < SYNC_PERIOD; i++) begin
				next_cycle();
				hs_raw = i < hs_high;
				vs_raw = i < vs_high;
				if (p == 2) begin
					@(negedge clk_sys);
					check_bit("hsync out", hs_raw ^ hs_inv, hs);
					check_bit("vsync out", vs_raw ^ vs_inv, vs);
				end
			end
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
	endtask

	always @(posedge clk_sys) begin
		if (io_ack && !ack_prev)
			ack_rises++;
		if (!io_ack && ack_prev)
			ack_falls++;
		ack_prev <= io_ack;
	end

	initial begin : compare_proc
		forever begin
			wait (check_pending);
			@(negedge clk_sys);
			if (exp_req.is_led)
				check_led(exp_req.led, led);
			else
				check_window(exp_req.win, window);
			check_pending = 1'b0;
		end
	end

	initial begin : watchdog
		repeat (N_TESTS * 2000) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles", N_TESTS * 2000);
		$display("tests failed");
		$finish;
	end

	initial begin : main_proc
		int   errs;
		int   rises0;
		int   falls0;
		dim_t w;
		dim_t h;
		lfsr    = 32'hf755;
		resetd  = 1'b1;
		io_sel  = 1'b0;
		io_req  = 1'b0;
		io_data = '0;
		aspect  = '0;
		hs_raw  = 1'b0;
		vs_raw  = 1'b0;
		m_size  = '{width: DEF_WIDTH, height: DEF_HEIGHT};
		m_scale = '0;
		m_led   = '0;
		repeat (RESET_CYCLES) next_cycle();
		resetd = 1'b0;

		// Handshake, unknown opcode frame then an LED frame
		errs = errors;
		check_bit("ack after reset", 1'b0, io_ack);
		rises0 = ack_rises;
		falls0 = ack_falls;
		frame_words.push_back(16'h0055);
		repeat (3) frame_words.push_back(host_word_t'(rand_bits(16)));
		send_frame();
		set_led(16'h00ff);
		check_count("ack rises", 6, ack_rises - rises0);
		check_count("ack falls", 6, ack_falls - falls0);
		end_test("handshake", errs);

		errs = errors;
		expect_led();
		set_led(16'hf0ff);
		expect_led();
		repeat (3) begin
			set_led(host_word_t'(rand_bits(16)));
			expect_led();
		end
		end_test("led", errs);

		errs = errors;
		set_random_aspect();
		set_timing(dim_t'(256 + rand_bits(11)), dim_t'(128 + rand_bits(10)));
		set_hset(1'b1, dim_t'(64 + rand_bits(11)));
		expect_window();
		end_test("free scale", errs);

		errs = errors;
		set_hset(1'b0, '0);
		set_vset('0);
		repeat (8) begin
			set_random_aspect();
			set_timing(dim_t'(256 + rand_bits(11)), dim_t'(128 + rand_bits(10)));
			expect_window();
		end
		// Zero ratio term skips the scaling
		set_aspect('0, dim_t'(1 + rand_bits(4)));
		expect_window();
		end_test("aspect", errs);

		errs = errors;
		for (int k = 0; k < 4; k++) begin
			w = dim_t'(512 + rand_bits(10));
			h = dim_t'(256 + rand_bits(9));
			set_random_aspect();
			set_timing(w, h);
			if (k[0])
				set_hset(1'b0, w - dim_t'(1 + rand_bits(8)));
			else
				set_hset(1'b0, w + dim_t'(1 + rand_bits(8)));
			if (k[1])
				set_vset(h - dim_t'(1 + rand_bits(7)));
			else
				set_vset(h + dim_t'(1 + rand_bits(7)));
			expect_window();
		end
		end_test("limits", errs);

		errs = errors;
		run_sync(6, 58);
		run_sync(58, 6);
		end_test("sync", errs);

		if (u_sys_core_top.u_sys_core_chk.fail_cnt != 0) begin
			errors += u_sys_core_top.u_sys_core_chk.fail_cnt;
			$display("Bound assertions reported %0d failures",
				u_sys_core_top.u_sys_core_chk.fail_cnt);
		end
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: video_pkg.sv
////////////////////////////////////////
// Video side definitions
// Dimension type, default resolution, window structs
////////////////////////////////////////
`default_nettype none

package video_pkg;

	localparam int DIM_W      = 12;
	localparam int SYNC_CNT_W = 16;

	typedef logic [DIM_W-1:0] dim_t;

	// 1080p until the host says otherwise
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

	typedef struct packed {dim_t width; dim_t height;} video_size_t;
	typedef struct packed {dim_t arx; dim_t ary;} aspect_t;
	typedef struct packed {dim_t hmin; dim_t hmax; dim_t vmin; dim_t vmax;} window_t;

endpackage

`default_nettype wire

// File: video_window.sv
////////////////////////////////////////
// Display window calculator
// Aspect scaling FSM, clamp and centring
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_window
	import hps_cfg_pkg::*, video_pkg::*;
(
	input  logic        clk_sys,
	input  logic        resetd,
	input  video_size_t i_size,
	input  scale_cfg_t  i_scale,
	input  aspect_t     i_aspect,
	output window_t     o_window
);

	typedef enum logic [2:0] {
		WS_CHOOSE, WS_W_START, WS_W_WAIT, WS_H_START, WS_H_WAIT, WS_CLAMP, WS_CENTRE
	} win_state_e;

	win_state_e state;
	dim_t       lim_w, lim_h;
	dim_t       wcalc, hcalc;
	dim_t       vid_w, vid_h;
	dim_t       h_off, v_off;
	window_t    win_next;
	logic       md_start, md_busy;
	dim_t       md_mul1, md_mul2, md_div, md_res;

	// Limits only ever shrink the output size
	assign lim_w = (i_scale.hset != '0 && i_scale.hset < i_size.width) ? i_scale.hset : i_size.width;
	assign lim_h = (i_scale.vset != '0 && i_scale.vset < i_size.height) ? i_scale.vset : i_size.height;

	assign h_off         = i_size.width - vid_w;
	assign v_off         = i_size.height - vid_h;
	assign win_next.hmin = h_off >> 1;
	assign win_next.hmax = win_next.hmin + vid_w - dim_t'(1);
	assign win_next.vmin = v_off >> 1;
	assign win_next.vmax = win_next.vmin + vid_h - dim_t'(1);

	ar_muldiv u_ar_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	////////////////////////////////////////
	// Sequencing, loops forever
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= WS_CHOOSE;
			md_start <= 1'b0;
			o_window <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				WS_CHOOSE: begin
					if (i_scale.free_scale || i_aspect.arx == '0 || i_aspect.ary == '0)
						state <= WS_CLAMP;
					else
						state <= WS_W_START;
				end
				WS_W_START: begin
					md_start <= 1'b1;
					state    <= WS_W_WAIT;
				end
				// Busy shows up one clock after start
				WS_W_WAIT:  if (!md_start && !md_busy) state <= WS_H_START;
				WS_H_START: begin
					md_start <= 1'b1;
					state    <= WS_H_WAIT;
				end
				WS_H_WAIT:  if (!md_start && !md_busy) state <= WS_CLAMP;
				WS_CLAMP:   state <= WS_CENTRE;
				WS_CENTRE: begin
					o_window <= win_next;
					state    <= WS_CHOOSE;
				end
				default:    state <= WS_CHOOSE;
			endcase
		end
	end

	////////////////////////////////////////
	// Datapath
	always_ff @(posedge clk_sys) begin
		case (state)
			WS_CHOOSE: begin
				wcalc <= lim_w;
				hcalc <= lim_h;
			end
			WS_W_START: begin
				md_mul1 <= lim_h;
				md_mul2 <= i_aspect.arx;
				md_div  <= i_aspect.ary;
			end
			WS_W_WAIT: wcalc <= md_res;
			WS_H_START: begin
				md_mul1 <= lim_w;
				md_mul2 <= i_aspect.ary;
				md_div  <= i_aspect.arx;
			end
			WS_H_WAIT: hcalc <= md_res;
			WS_CLAMP: begin
				vid_w <= (wcalc > lim_w) ? lim_w : wcalc;
				vid_h <= (hcalc > lim_h) ? lim_h : hcalc;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire
